/* src/axil_pkg.sv */
// bus widths, vector typedefs, response codes and AXI4-Lite channel structs
package axil_pkg;

    // bus geometry
    localparam int axil_addr_w = 16;
    localparam int axil_data_w = 32;
    localparam int axil_strb_w = axil_data_w / 8;

    typedef logic [axil_addr_w-1:0] addr_t;
    typedef logic [axil_data_w-1:0] data_t;
    typedef logic [axil_strb_w-1:0] strb_t;
    typedef logic [1:0]             resp_t;

    // response codes, only the two used here
    localparam resp_t resp_okay   = 2'd0;
    localparam resp_t resp_decerr = 2'd3;

    // write address channel payload
    typedef struct packed {
        addr_t addr;
    } axil_aw_t;

    // write data channel payload
    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    // write response channel payload
    typedef struct packed {
        resp_t resp;
    } axil_b_t;

    // read address channel payload
    typedef struct packed {
        addr_t addr;
    } axil_ar_t;

    // read data channel payload
    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_r_t;

endpackage

/* src/axil_wr_decode.sv */
// write address decoder with DECERR responder and B channel merge
`timescale 1ns/1ps

module axil_wr_decode import axil_pkg::*; #(
    parameter int ram_addr_w = 12
) (
    input  logic     clk,
    input  logic     rst,
    input  axil_aw_t s_aw,
    input  logic     s_awvalid,
    output logic     s_awready,
    input  axil_w_t  s_w,
    input  logic     s_wvalid,
    output logic     s_wready,
    output axil_b_t  s_b,
    output logic     s_bvalid,
    input  logic     s_bready,
    output axil_aw_t m_aw,
    output logic     m_awvalid,
    input  logic     m_awready,
    output axil_w_t  m_w,
    output logic     m_wvalid,
    input  logic     m_wready,
    input  axil_b_t  m_b,
    input  logic     m_bvalid,
    output logic     m_bready
);

    localparam axil_b_t b_decerr = '{resp: resp_decerr};

    logic in_win;
    logic busy;
    logic err_ready;
    logic err_bvalid;
    logic err_req;
    logic req_xfer;
    logic b_xfer;

    // anything at or above 2**ram_addr_w falls outside the RAM window
    assign in_win = (s_aw.addr >> ram_addr_w) == '0;

    // RAM side sees the request only while no write is outstanding
    assign m_aw      = s_aw;
    assign m_w       = s_w;
    assign m_awvalid = s_awvalid && in_win && !busy;
    assign m_wvalid  = s_wvalid && in_win && !busy;

    // error responder takes both halves together, like the RAM does
    assign err_req = s_awvalid && s_wvalid && !in_win && !busy && !err_ready;

    assign s_awready = m_awready || err_ready;
    assign s_wready  = m_wready || err_ready;

    // response merge, at most one source is valid at a time
    assign s_bvalid = m_bvalid || err_bvalid;
    assign s_b      = err_bvalid ? b_decerr : m_b;
    assign m_bready = s_bready && !err_bvalid;

    assign req_xfer = s_awvalid && s_awready;
    assign b_xfer   = s_bvalid && s_bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            err_ready  <= 1'b0;
            err_bvalid <= 1'b0;
        end else begin
            // ready is a single cycle pulse
            err_ready <= err_req;

            if (err_req) begin
                err_bvalid <= 1'b1;
            end else if (s_bready) begin
                err_bvalid <= 1'b0;
            end

            // a response in the accept cycle finishes the transaction at once
            if (b_xfer) begin
                busy <= 1'b0;
            end else if (req_xfer) begin
                busy <= 1'b1;
            end
        end
    end

    // a B response only exists for a write that is accepted or outstanding
    a_no_idle_bvalid: assert property (@(posedge clk) disable iff (rst)
        s_bvalid |-> busy || req_xfer);

endmodule

/* src/axil_rd_decode.sv */
// read address decoder with DECERR responder and R channel merge
`timescale 1ns/1ps

module axil_rd_decode import axil_pkg::*; #(
    parameter int ram_addr_w = 12
) (
    input  logic     clk,
    input  logic     rst,
    input  axil_ar_t s_ar,
    input  logic     s_arvalid,
    output logic     s_arready,
    output axil_r_t  s_r,
    output logic     s_rvalid,
    input  logic     s_rready,
    output axil_ar_t m_ar,
    output logic     m_arvalid,
    input  logic     m_arready,
    input  axil_r_t  m_r,
    input  logic     m_rvalid,
    output logic     m_rready
);

    // zero data goes out with every decode error
    localparam axil_r_t r_decerr = '{data: '0, resp: resp_decerr};

    logic in_win;
    logic busy;
    logic err_ready;
    logic err_rvalid;
    logic err_req;
    logic req_xfer;
    logic r_xfer;

    assign in_win = (s_ar.addr >> ram_addr_w) == '0;

    assign m_ar      = s_ar;
    assign m_arvalid = s_arvalid && in_win && !busy;

    assign err_req = s_arvalid && !in_win && !busy && !err_ready;

    assign s_arready = m_arready || err_ready;

    assign s_rvalid = m_rvalid || err_rvalid;
    assign s_r      = err_rvalid ? r_decerr : m_r;
    assign m_rready = s_rready && !err_rvalid;

    assign req_xfer = s_arvalid && s_arready;
    assign r_xfer   = s_rvalid && s_rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            err_ready  <= 1'b0;
            err_rvalid <= 1'b0;
        end else begin
            err_ready <= err_req;

            if (err_req) begin
                err_rvalid <= 1'b1;
            end else if (s_rready) begin
                err_rvalid <= 1'b0;
            end

            // held through the RAM pipeline until the data is taken
            if (r_xfer) begin
                busy <= 1'b0;
            end else if (req_xfer) begin
                busy <= 1'b1;
            end
        end
    end

    // covers both the error register and the RAM output stages
    a_r_stable: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> $stable(s_r));

endmodule

/* src/axil_ram.sv */
// AXI4-Lite block RAM with byte strobes and optional read output register
`timescale 1ns/1ps

module axil_ram import axil_pkg::*; #(
    parameter int ram_addr_w      = 12,
    parameter bit pipeline_output = 1'b0
) (
    input  logic     clk,
    input  logic     rst,
    input  axil_aw_t aw,
    input  logic     awvalid,
    output logic     awready,
    input  axil_w_t  w,
    input  logic     wvalid,
    output logic     wready,
    output axil_b_t  b,
    output logic     bvalid,
    input  logic     bready,
    input  axil_ar_t ar,
    input  logic     arvalid,
    output logic     arready,
    output axil_r_t  r,
    output logic     rvalid,
    input  logic     rready
);

    localparam int word_w = ram_addr_w - $clog2(axil_strb_w);
    localparam int byte_w = axil_data_w / axil_strb_w;

    typedef enum logic [1:0] {
        wr_idle,
        wr_accept,
        wr_resp
    } wr_state_t;

    typedef enum logic [1:0] {
        rd_idle,
        rd_accept,
        rd_hold
    } rd_state_t;

    data_t mem [2**word_w];

    wr_state_t wr_state;
    wr_state_t wr_next;
    rd_state_t rd_state;
    rd_state_t rd_next;

    logic [word_w-1:0] wr_word;
    logic [word_w-1:0] rd_word;
    logic mem_wr_en;
    logic mem_rd_en;
    logic rvalid_q;
    logic rd_adv;
    data_t rdata_q;
    data_t pipe_data;
    logic pipe_valid;

    // byte address to word index
    assign wr_word = aw.addr[ram_addr_w-1:$clog2(axil_strb_w)];
    assign rd_word = ar.addr[ram_addr_w-1:$clog2(axil_strb_w)];

    // block RAM powers up cleared
    initial begin
        for (int i = 0; i < 2**word_w; i++) begin
            mem[i] = '0;
        end
    end

    // write side, the accept state drives the ready pulse
    assign awready = wr_state == wr_accept;
    assign wready  = wr_state == wr_accept;
    assign bvalid  = wr_state != wr_idle;
    assign b       = '{resp: resp_okay};

    // a new write needs the B slot empty or draining this cycle
    assign mem_wr_en = awvalid && wvalid &&
        (wr_state == wr_idle || (wr_state == wr_resp && bready));

    always_comb begin
        if (mem_wr_en) begin
            wr_next = wr_accept;
        end else if (bvalid && !bready) begin
            wr_next = wr_resp;
        end else begin
            wr_next = wr_idle;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < axil_strb_w; i++) begin
            if (mem_wr_en && w.strb[i]) begin
                mem[wr_word][byte_w*i +: byte_w] <= w.data[byte_w*i +: byte_w];
            end
        end
    end

    // read side, first stage is the RAM output register
    assign arready  = rd_state == rd_accept;
    assign rvalid_q = rd_state != rd_idle;

    // first stage empties on rready, or into an empty pipeline stage
    assign rd_adv = rready || (pipeline_output && !pipe_valid);

    assign mem_rd_en = arvalid &&
        (rd_state == rd_idle || (rd_state == rd_hold && rd_adv));

    always_comb begin
        if (mem_rd_en) begin
            rd_next = rd_accept;
        end else if (rvalid_q && !rd_adv) begin
            rd_next = rd_hold;
        end else begin
            rd_next = rd_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rd_en) begin
            rdata_q <= mem[rd_word];
        end
        if (!pipe_valid || rready) begin
            pipe_data <= rdata_q;
        end
    end

    assign rvalid = pipeline_output ? pipe_valid : rvalid_q;
    assign r      = '{data: pipeline_output ? pipe_data : rdata_q, resp: resp_okay};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state   <= wr_idle;
            rd_state   <= rd_idle;
            pipe_valid <= 1'b0;
        end else begin
            wr_state <= wr_next;
            rd_state <= rd_next;
            if (!pipe_valid || rready) begin
                pipe_valid <= rvalid_q;
            end
        end
    end

    // the manager keeps both valids up until the ready pulse
    a_awready_valid: assert property (@(posedge clk) disable iff (rst)
        awready |-> awvalid && wvalid);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid);

endmodule

/* src/axil_ram_sub.sv */
// memory subsystem top level, write and read decoders in front of the RAM
`timescale 1ns/1ps

module axil_ram_sub import axil_pkg::*; #(
    parameter int ram_addr_w      = 12,
    parameter bit pipeline_output = 1'b0
) (
    input  logic     clk,
    input  logic     rst,
    input  axil_aw_t s_aw,
    input  logic     s_awvalid,
    output logic     s_awready,
    input  axil_w_t  s_w,
    input  logic     s_wvalid,
    output logic     s_wready,
    output axil_b_t  s_b,
    output logic     s_bvalid,
    input  logic     s_bready,
    input  axil_ar_t s_ar,
    input  logic     s_arvalid,
    output logic     s_arready,
    output axil_r_t  s_r,
    output logic     s_rvalid,
    input  logic     s_rready
);

    // decoder to RAM channels
    axil_aw_t m_aw;
    axil_w_t  m_w;
    axil_b_t  m_b;
    axil_ar_t m_ar;
    axil_r_t  m_r;
    logic     m_awvalid;
    logic     m_awready;
    logic     m_wvalid;
    logic     m_wready;
    logic     m_bvalid;
    logic     m_bready;
    logic     m_arvalid;
    logic     m_arready;
    logic     m_rvalid;
    logic     m_rready;

    axil_wr_decode #(
        .ram_addr_w (ram_addr_w)
    ) wr_decode_i (
        .clk       (clk),
        .rst       (rst),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .m_b       (m_b),
        .m_bvalid  (m_bvalid),
        .m_bready  (m_bready)
    );

    axil_rd_decode #(
        .ram_addr_w (ram_addr_w)
    ) rd_decode_i (
        .clk       (clk),
        .rst       (rst),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

    axil_ram #(
        .ram_addr_w      (ram_addr_w),
        .pipeline_output (pipeline_output)
    ) ram_i (
        .clk     (clk),
        .rst     (rst),
        .aw      (m_aw),
        .awvalid (m_awvalid),
        .awready (m_awready),
        .w       (m_w),
        .wvalid  (m_wvalid),
        .wready  (m_wready),
        .b       (m_b),
        .bvalid  (m_bvalid),
        .bready  (m_bready),
        .ar      (m_ar),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .r       (m_r),
        .rvalid  (m_rvalid),
        .rready  (m_rready)
    );

endmodule

/* test/tb_axil_ram_sub.sv */
// testbench for the AXI4-Lite memory subsystem with shadow model, compare process and timeout
`timescale 1ns/1ps

module tb_axil_ram_sub import axil_pkg::*; ();

    localparam int ram_w = 12;
    localparam int n_txn = 562;
    localparam int cycle_limit = 20 * n_txn + 200;
    localparam addr_t win_size = addr_t'(2**ram_w);
    localparam addr_t win_mask = addr_t'(2**ram_w - 1);
    // random traffic stays within 64 words so reads see earlier writes
    localparam addr_t hot_mask = 16'h00fc;

    logic     clk;
    logic     rst;
    axil_aw_t s_aw;
    logic     s_awvalid;
    logic     s_awready;
    axil_w_t  s_w;
    logic     s_wvalid;
    logic     s_wready;
    axil_b_t  s_b;
    logic     s_bvalid;
    logic     s_bready;
    axil_ar_t s_ar;
    logic     s_arvalid;
    logic     s_arready;
    axil_r_t  s_r;
    logic     s_rvalid;
    logic     s_rready;

    // byte-wide shadow of the RAM window
    logic [7:0] shadow [2**ram_w];
    resp_t   b_exp [$];
    axil_r_t r_exp [$];
    int b_done = 0;
    int r_done = 0;
    int seed = 45;
    int cycles = 0;
    bit bp_en = 1'b0;

    axil_ram_sub #(
        .ram_addr_w (ram_w)
    ) axil_ram_sub_i (
        .clk       (clk),
        .rst       (rst),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // expected response for an access with data from the shadow
    function automatic axil_r_t expected_response(addr_t addr);
        axil_r_t exp;
        logic [1:0] lane;
        exp.data = '0;
        exp.resp = resp_decerr;
        if (addr < win_size) begin
            for (int i = 0; i < 4; i++) begin
                lane = 2'(i);
                exp.data[8*i +: 8] = shadow[{addr[ram_w-1:2], lane}];
            end
            exp.resp = resp_okay;
        end
        return exp;
    endfunction

    function automatic void update_shadow(addr_t addr, data_t data, strb_t strb);
        logic [1:0] lane;
        if (addr < win_size) begin
            for (int i = 0; i < 4; i++) begin
                lane = 2'(i);
                if (strb[i]) begin
                    shadow[{addr[ram_w-1:2], lane}] = data[8*i +: 8];
                end
            end
        end
    endfunction

    task automatic write_txn(addr_t addr, data_t data, strb_t strb, bit check_lat);
        axil_r_t exp;
        int n;
        int target;
        exp = expected_response(addr);
        b_exp.push_back(exp.resp);
        update_shadow(addr, data, strb);
        target = b_done + 1;
        @(posedge clk);
        s_aw.addr <= addr;
        s_w.data  <= data;
        s_w.strb  <= strb;
        s_awvalid <= 1'b1;
        s_wvalid  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(s_awready && s_wready));
        if (check_lat) begin
            assert (n == 2 && s_bvalid) else
                report_error($sformatf("[FAIL] write handshake cycles %h expected 2, s_bvalid %h",
                    n, s_bvalid));
        end
        @(posedge clk);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        do @(negedge clk); while (b_done < target);
    endtask

    task automatic read_txn(addr_t addr, bit check_lat);
        int n;
        int target;
        r_exp.push_back(expected_response(addr));
        target = r_done + 1;
        @(posedge clk);
        s_ar.addr <= addr;
        s_arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!s_arready);
        if (check_lat) begin
            assert (n == 2 && s_rvalid) else
                report_error($sformatf("[FAIL] read handshake cycles %h expected 2, s_rvalid %h",
                    n, s_rvalid));
        end
        @(posedge clk);
        s_arvalid <= 1'b0;
        do @(negedge clk); while (r_done < target);
    endtask

    task automatic random_txn();
        logic [31:0] r;
        data_t d;
        addr_t addr;
        r = $random(seed);
        d = $random(seed);
        addr = r[31:16] & hot_mask;
        // one in four goes above the window and aliases a hot word
        if (r[1:0] == 2'd3) begin
            addr = addr | win_size | (r[31:16] & ~win_mask);
        end
        if (r[6]) begin
            write_txn(addr, d, r[5:2], 1'b0);
        end else begin
            read_txn(addr, 1'b0);
        end
    endtask

    // response readies toggle at random while back-pressure is on
    initial begin : backpressure
        logic [31:0] r;
        s_bready <= 1'b0;
        s_rready <= 1'b0;
        forever begin
            @(posedge clk);
            if (bp_en) begin
                r = $random(seed);
                s_bready <= r[0];
                s_rready <= r[1];
            end else begin
                s_bready <= 1'b1;
                s_rready <= 1'b1;
            end
        end
    end

    // outputs sampled at the falling edge before the transferring rising edge
    initial begin : compare
        resp_t   exp_resp;
        axil_r_t exp_r;
        axil_b_t b_last;
        axil_r_t r_last;
        bit b_hold;
        bit r_hold;
        b_hold = 1'b0;
        r_hold = 1'b0;
        forever begin
            @(negedge clk);
            // a response left waiting must not change
            if (b_hold) begin
                assert (s_bvalid && s_b == b_last) else
                    report_error($sformatf("[FAIL] s_b not held, valid %h resp %h expected resp %h",
                        s_bvalid, s_b.resp, b_last.resp));
            end
            if (r_hold) begin
                assert (s_rvalid && s_r == r_last) else
                    report_error($sformatf("[FAIL] s_r not held, valid %h got %h expected %h",
                        s_rvalid, s_r, r_last));
            end
            if (s_bvalid && s_bready) begin
                assert (b_exp.size() != 0) else
                    report_error("a write response arrived with no write outstanding");
                exp_resp = b_exp.pop_front();
                assert (s_b.resp == exp_resp) else
                    report_error($sformatf("[FAIL] s_b.resp got %h expected %h",
                        s_b.resp, exp_resp));
                b_done++;
            end
            if (s_rvalid && s_rready) begin
                assert (r_exp.size() != 0) else
                    report_error("a read response arrived with no read outstanding");
                exp_r = r_exp.pop_front();
                assert (s_r.resp == exp_r.resp) else
                    report_error($sformatf("[FAIL] s_r.resp got %h expected %h",
                        s_r.resp, exp_r.resp));
                assert (s_r.data == exp_r.data) else
                    report_error($sformatf("[FAIL] s_r.data got %h expected %h",
                        s_r.data, exp_r.data));
                r_done++;
            end
            b_hold = s_bvalid && !s_bready;
            b_last = s_b;
            r_hold = s_rvalid && !s_rready;
            r_last = s_r;
        end
    end

    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the test did not finish within %0d cycles", cycle_limit);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped by the cycle limit");
    end

    initial begin : main
        logic [31:0] r;
        data_t d;
        addr_t addr;
        shadow = '{default: 8'h00};
        rst       <= 1'b1;
        s_aw      <= '0;
        s_awvalid <= 1'b0;
        s_w       <= '0;
        s_wvalid  <= 1'b0;
        s_ar      <= '0;
        s_arvalid <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!s_awready && !s_wready && !s_bvalid && !s_arready && !s_rvalid) else
            report_error($sformatf(
                "[FAIL] after reset awready %h wready %h bvalid %h arready %h rvalid %h",
                s_awready, s_wready, s_bvalid, s_arready, s_rvalid));

        // idle latency of one write and one read
        d = $random(seed);
        write_txn(16'h0010, d, 4'hf, 1'b1);
        read_txn(16'h0010, 1'b1);

        // full words spread over the window
        for (int i = 0; i < 16; i++) begin
            d = $random(seed);
            write_txn(addr_t'(260 * i), d, 4'hf, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            read_txn(addr_t'(260 * i), 1'b0);
        end

        // random strobes over eight words
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            d = $random(seed);
            addr = 16'h0800 | {11'd0, r[4:2], 2'b00};
            write_txn(addr, d, r[8:5], 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            read_txn(16'h0800 | addr_t'(4 * i), 1'b0);
        end

        // accesses above the window alias the words just written
        for (int i = 0; i < 8; i++) begin
            d = $random(seed);
            addr = 16'h0800 | addr_t'(4 * i) | win_size | (i[0] ? 16'h8000 : 16'h0000);
            write_txn(addr, d, 4'hf, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            addr = 16'h0800 | addr_t'(4 * i) | win_size | (i[0] ? 16'h8000 : 16'h0000);
            read_txn(addr, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            read_txn(16'h0800 | addr_t'(4 * i), 1'b0);
        end

        bp_en = 1'b1;
        repeat (64) random_txn();
        // long interleaved mix under back-pressure
        repeat (400) random_txn();

        assert (b_exp.size() == 0 && r_exp.size() == 0) else
            report_error("responses still pending at the end of the test");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* axil_ram_sub.f */
src/axil_pkg.sv
src/axil_wr_decode.sv
src/axil_rd_decode.sv
src/axil_ram.sv
src/axil_ram_sub.sv
test/tb_axil_ram_sub.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_axil_ram_sub -f axil_ram_sub.f

./obj_dir/Vtb_axil_ram_sub | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
